/* proc_core.f */
+incdir+rtl
rtl/proc_isa_pkg.sv
rtl/proc_mem_pkg.sv
rtl/proc_fetch.sv
rtl/proc_imem_queue.sv
rtl/proc_exec.sv
rtl/proc_core.sv
bench/proc_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the processor core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f proc_core.f \
  --top-module proc_core_tb \
  -o proc_core_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/proc_core_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit 1
fi

exit 0

/* bench/proc_core_tb.sv */
// Processor core testbench
// Random programs run against an ISA model, with a random-latency memory

`timescale 1ns/1ps

`include "proc_cfg.svh"

module proc_core_tb
  import proc_isa_pkg::*;
  import proc_mem_pkg::*;
();

  localparam int NUM_PROGS      = 8;
  localparam int PROG_LEN       = 24;
  localparam int RESET_CYCLES   = 10;
  localparam int TIMEOUT_CYCLES = NUM_PROGS * PROG_LEN * 32;

  logic      clk;
  logic      rst_n;
  mem_req_t  imemreq_msg;
  logic      imemreq_val;
  logic      imemreq_rdy;
  mem_resp_t imemresp_msg;
  logic      imemresp_val;
  logic      imemresp_rdy;
  word_t     to_mngr_msg;
  logic      to_mngr_val;
  logic      to_mngr_rdy;
  logic      halted;

  integer    seed;
  int        cycle_count;
  word_t     prog [PROG_LEN];
  word_t     exp_out [$];
  addr_t     exp_target [$];
  int        exp_out_total;
  int        out_count;
  mem_resp_t pend_resp [$];
  int        pend_due [$];
  logic      first_req;
  mem_req_t  last_req;
  logic      mngr_wait;
  word_t     mngr_last;

  proc_core i_proc_core (
    .clk          (clk),
    .rst_n        (rst_n),
    .imemreq_msg  (imemreq_msg),
    .imemreq_val  (imemreq_val),
    .imemreq_rdy  (imemreq_rdy),
    .imemresp_msg (imemresp_msg),
    .imemresp_val (imemresp_val),
    .imemresp_rdy (imemresp_rdy),
    .to_mngr_msg  (to_mngr_msg),
    .to_mngr_val  (to_mngr_val),
    .to_mngr_rdy  (to_mngr_rdy),
    .halted       (halted)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ----------------------------------------------------------------------
  // Error handling
  // ----------------------------------------------------------------------

  task automatic abort_run();
    $display("Some tests failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_value(input string name, input word_t actual, input word_t expected);
    if (actual !== expected) begin
      $display("[FAIL] %s: actual 0x%08h, expected 0x%08h", name, actual, expected);
      abort_run();
    end
  endtask

  // ----------------------------------------------------------------------
  // Program generation and ISA model
  // ----------------------------------------------------------------------

  task automatic build_program();
    logic [31:0] r;
    logic [3:0]  op;
    int          sel;
    int          span;
    for (int i = 0; i < PROG_LEN - 1; i++) begin
      r   = $random(seed);
      sel = int'({$random(seed)} % 10);
      case (sel)
        0:       op = 4'hA;  // unlisted code runs as a no-op
        1:       op = OP_ADD;
        2:       op = OP_SUB;
        3:       op = OP_AND;
        4, 5:    op = OP_ADDI;
        6:       op = (i < PROG_LEN - 2) ? OP_BNE : OP_NOP;
        7, 8:    op = OP_OUT;
        default: op = OP_NOP;
      endcase
      prog[i] = {op, r[27:19], 3'b000, r[15:0]};
      // Forward jumps only and never past the final HALT
      if (op == OP_BNE) begin
        span = PROG_LEN - 2 - i;
        if (span > 5) begin
          span = 5;
        end
        prog[i][15:0] = 16'({$random(seed)} % (span + 1));
      end
    end
    prog[PROG_LEN-1] = {OP_HALT, 28'd0};
  endtask

  task automatic run_model();
    word_t regs [8];
    word_t w;
    word_t a;
    word_t b;
    word_t imm;
    word_t res;
    logic  wen;
    logic  done;
    int    idx;
    for (int k = 0; k < 8; k++) begin
      regs[k] = '0;
    end
    exp_out.delete();
    exp_target.delete();
    idx  = 0;
    done = 1'b0;
    while (!done) begin
      w   = (idx < PROG_LEN) ? prog[idx] : {OP_HALT, 28'd0};
      a   = regs[w[24:22]];
      b   = regs[w[21:19]];
      imm = {{16{w[15]}}, w[15:0]};
      idx = idx + 1;
      res = '0;
      wen = 1'b0;
      case (w[31:28])
        OP_ADD: begin
          res = a + b;
          wen = 1'b1;
        end
        OP_SUB: begin
          res = a - b;
          wen = 1'b1;
        end
        OP_AND: begin
          res = a & b;
          wen = 1'b1;
        end
        OP_ADDI: begin
          res = a + imm;
          wen = 1'b1;
        end
        OP_BNE: begin
          if (a != b) begin
            idx = idx + int'($signed(w[15:0]));
            exp_target.push_back(`PROC_RESET_VECTOR + 32'(idx * 4));
          end
        end
        OP_OUT:  exp_out.push_back(a);
        OP_HALT: done = 1'b1;
        default: ;
      endcase
      if (wen && (w[27:25] != 3'd0)) begin
        regs[w[27:25]] = res;
      end
    end
    exp_out_total = exp_out.size();
  endtask

  // ----------------------------------------------------------------------
  // Memory model and monitors
  // ----------------------------------------------------------------------

  function automatic word_t fetch_word(input addr_t addr);
    addr_t offset;
    int    idx;
    offset = addr - `PROC_RESET_VECTOR;
    if (offset < 32'(PROG_LEN * 4)) begin
      idx = int'(offset >> 2);
      return prog[idx];
    end
    return {OP_HALT, 28'd0};
  endfunction

  task automatic check_request();
    if (first_req) begin
      check_value("imemreq_msg.addr", imemreq_msg.addr, `PROC_RESET_VECTOR);
      check_value("imemreq_msg.tag", word_t'(imemreq_msg.tag), 32'd0);
      first_req = 1'b0;
    end else if (imemreq_msg.tag == last_req.tag) begin
      check_value("imemreq_msg.addr", imemreq_msg.addr, last_req.addr + 32'd4);
    end else if (exp_target.size() == 0) begin
      $display("Request epoch changed although the model took no further branch");
      abort_run();
    end else begin
      check_value("imemreq_msg.addr", imemreq_msg.addr, exp_target.pop_front());
    end
    last_req = imemreq_msg;
  endtask

  task automatic serve_memory();
    mem_resp_t resp;
    // A halted core takes no more responses
    if (halted) begin
      check_value("imemresp_rdy", word_t'(imemresp_rdy), 32'd0);
    end
    if (imemresp_val && imemresp_rdy) begin
      void'(pend_resp.pop_front());
      void'(pend_due.pop_front());
    end
    if (imemreq_val && imemreq_rdy) begin
      check_request();
      resp.tag  = imemreq_msg.tag;
      resp.data = fetch_word(imemreq_msg.addr);
      pend_resp.push_back(resp);
      pend_due.push_back(cycle_count + int'({$random(seed)} % 4));
    end
    // Responses leave strictly in request order
    if (pend_resp.size() > 0 && pend_due[0] <= cycle_count) begin
      imemresp_val <= 1'b1;
      imemresp_msg <= pend_resp[0];
    end else begin
      imemresp_val <= 1'b0;
    end
  endtask

  task automatic check_output();
    if (mngr_wait) begin
      check_value("to_mngr_val", word_t'(to_mngr_val), 32'd1);
      check_value("to_mngr_msg", to_mngr_msg, mngr_last);
    end
    if (to_mngr_val && to_mngr_rdy) begin
      if (exp_out.size() == 0) begin
        $display("The core sent more to-manager values than the model produced");
        abort_run();
      end else begin
        check_value("to_mngr_msg", to_mngr_msg, exp_out.pop_front());
        out_count++;
      end
    end
    mngr_wait = to_mngr_val && !to_mngr_rdy;
    mngr_last = to_mngr_msg;
  endtask

  always @(posedge clk) begin
    cycle_count++;
    imemreq_rdy <= (({$random(seed)} % 4) != 0);
    to_mngr_rdy <= (({$random(seed)} % 10) < 6);
    if (!rst_n) begin
      pend_resp.delete();
      pend_due.delete();
      imemresp_val <= 1'b0;
      first_req = 1'b1;
      mngr_wait = 1'b0;
      out_count = 0;
    end else begin
      serve_memory();
      check_output();
    end
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the core never finished", cycle_count);
      abort_run();
    end
  end

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------

  initial begin
    seed         = 13866;
    cycle_count  = 0;
    rst_n        = 1'b0;
    imemreq_rdy  = 1'b0;
    imemresp_msg = '0;
    imemresp_val = 1'b0;
    to_mngr_rdy  = 1'b0;
    for (int p = 0; p < NUM_PROGS; p++) begin
      build_program();
      run_model();
      @(posedge clk);
      rst_n <= 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);
      check_value("imemreq_val", word_t'(imemreq_val), 32'd0);
      check_value("to_mngr_val", word_t'(to_mngr_val), 32'd0);
      check_value("halted", word_t'(halted), 32'd0);
      while (!halted) @(posedge clk);
      // Queued requests and the last OUT may still drain after halt
      while (to_mngr_val || imemreq_val) @(posedge clk);
      repeat (2) begin
        @(posedge clk);
        check_value("imemreq_val", word_t'(imemreq_val), 32'd0);
      end
      check_value("to_mngr transfer count", word_t'(out_count), word_t'(exp_out_total));
      $display("Program %0d finished with %0d values out", p, out_count);
    end
    $display("All tests passed");
    $finish;
  end

endmodule

/* rtl/proc_core.sv */
// Processor core top level
// Connects fetch, the instruction request queue and execute

`timescale 1ns/1ps

module proc_core
  import proc_mem_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,

  // Instruction memory request port
  output mem_req_t  imemreq_msg,
  output logic      imemreq_val,
  input  logic      imemreq_rdy,

  // Instruction memory response port
  input  mem_resp_t imemresp_msg,
  input  logic      imemresp_val,
  output logic      imemresp_rdy,

  // To-manager stream
  output word_t     to_mngr_msg,
  output logic      to_mngr_val,
  input  logic      to_mngr_rdy,

  output logic      halted
);

  // Fetch side of the request queue
  mem_req_t imemreq_enq_msg;
  logic     imemreq_enq_val;
  logic     imemreq_enq_rdy;

  // Execute to fetch
  logic     redir_val;
  addr_t    redir_pc;
  mem_tag_t epoch;

  // ----------------------------------------------------------------------
  // Fetch
  // ----------------------------------------------------------------------

  proc_fetch i_fetch (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_msg   (imemreq_enq_msg),
    .req_val   (imemreq_enq_val),
    .req_rdy   (imemreq_enq_rdy),
    .redir_val (redir_val),
    .redir_pc  (redir_pc),
    .epoch     (epoch),
    .halted    (halted)
  );

  // ----------------------------------------------------------------------
  // Bypass queue
  // ----------------------------------------------------------------------

  proc_imem_queue i_imem_queue (
    .clk     (clk),
    .rst_n   (rst_n),
    .enq_msg (imemreq_enq_msg),
    .enq_val (imemreq_enq_val),
    .enq_rdy (imemreq_enq_rdy),
    .deq_msg (imemreq_msg),
    .deq_val (imemreq_val),
    .deq_rdy (imemreq_rdy)
  );

  // ----------------------------------------------------------------------
  // Execute
  // ----------------------------------------------------------------------

  proc_exec i_exec (
    .clk       (clk),
    .rst_n     (rst_n),
    .resp_msg  (imemresp_msg),
    .resp_val  (imemresp_val),
    .resp_rdy  (imemresp_rdy),
    .redir_val (redir_val),
    .redir_pc  (redir_pc),
    .epoch     (epoch),
    .halted    (halted),
    .mngr_msg  (to_mngr_msg),
    .mngr_val  (to_mngr_val),
    .mngr_rdy  (to_mngr_rdy)
  );

endmodule

/* rtl/proc_exec.sv */
// Execute stage
// Drops stale fetches, decodes and runs instructions, resolves branches
// and drives the to-manager output register

`timescale 1ns/1ps

`include "proc_cfg.svh"

module proc_exec
  import proc_isa_pkg::*;
  import proc_mem_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,

  // Instruction responses
  input  mem_resp_t resp_msg,
  input  logic      resp_val,
  output logic      resp_rdy,

  // Redirect and state towards fetch
  output logic      redir_val,
  output addr_t     redir_pc,
  output mem_tag_t  epoch,
  output logic      halted,

  // To-manager stream
  output word_t     mngr_msg,
  output logic      mngr_val,
  input  logic      mngr_rdy
);

  localparam int NUM_REGS = `PROC_NUM_REGS;

  word_t regs [NUM_REGS];
  addr_t exp_pc;
  inst_t inst;
  logic  drop;
  logic  out_busy;
  logic  fire;
  logic  exec_fire;
  word_t rs_val;
  word_t rt_val;
  word_t imm_ext;
  word_t alu_out;
  logic  wen;
  logic  taken;

  // ----------------------------------------------------------------------
  // Epoch check and handshake
  // ----------------------------------------------------------------------

  assign inst     = inst_t'(resp_msg.data);
  assign drop     = (resp_msg.tag != epoch);
  assign out_busy = mngr_val && !mngr_rdy;

  // Stale responses drain even when the output is stalled
  assign resp_rdy  = !halted && (drop || !out_busy);
  assign fire      = resp_val && resp_rdy;
  assign exec_fire = fire && !drop;

  // ----------------------------------------------------------------------
  // Decode and ALU
  // ----------------------------------------------------------------------

  assign rs_val  = (inst.rs == '0) ? '0 : regs[inst.rs];
  assign rt_val  = (inst.rt == '0) ? '0 : regs[inst.rt];
  assign imm_ext = {{16{inst.imm[15]}}, inst.imm};

  always_comb begin
    alu_out = '0;
    wen     = 1'b0;
    case (inst.opcode)
      OP_ADD: begin
        alu_out = rs_val + rt_val;
        wen     = 1'b1;
      end
      OP_SUB: begin
        alu_out = rs_val - rt_val;
        wen     = 1'b1;
      end
      OP_AND: begin
        alu_out = rs_val & rt_val;
        wen     = 1'b1;
      end
      OP_ADDI: begin
        alu_out = rs_val + imm_ext;
        wen     = 1'b1;
      end
      default: begin
        alu_out = '0;
        wen     = 1'b0;
      end
    endcase
  end

  // Branch target is relative to the instruction after the BNE
  assign taken     = exec_fire && (inst.opcode == OP_BNE) && (rs_val != rt_val);
  assign redir_val = taken;
  assign redir_pc  = exp_pc + 32'd4 + {imm_ext[29:0], 2'b00};

  // ----------------------------------------------------------------------
  // Register file
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (exec_fire && wen && (inst.rd != '0)) begin
      regs[inst.rd] <= alu_out;
    end
  end

  // ----------------------------------------------------------------------
  // Control state
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      exp_pc   <= `PROC_RESET_VECTOR;
      epoch    <= '0;
      halted   <= 1'b0;
      mngr_val <= 1'b0;
    end else begin
      if (exec_fire) begin
        exp_pc <= taken ? redir_pc : exp_pc + 32'd4;
      end
      if (taken) begin
        epoch <= ~epoch;
      end
      if (exec_fire && (inst.opcode == OP_HALT)) begin
        halted <= 1'b1;
      end
      // New OUT may load in the same cycle the old value leaves
      if (exec_fire && (inst.opcode == OP_OUT)) begin
        mngr_val <= 1'b1;
      end else if (mngr_rdy) begin
        mngr_val <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (exec_fire && (inst.opcode == OP_OUT)) begin
      mngr_msg <= rs_val;
    end
  end

  a_mngr_hold : assert property (
    @(posedge clk) disable iff (!rst_n)
    (mngr_val && !mngr_rdy) |=> (mngr_val && $stable(mngr_msg))
  ) else $error("to-manager message changed while waiting");

endmodule

/* rtl/proc_imem_queue.sv */
// Instruction request bypass queue
// Circular buffer that passes requests straight through when empty

`timescale 1ns/1ps

`include "proc_cfg.svh"

module proc_imem_queue
  import proc_mem_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,

  input  mem_req_t enq_msg,
  input  logic     enq_val,
  output logic     enq_rdy,

  output mem_req_t deq_msg,
  output logic     deq_val,
  input  logic     deq_rdy
);

  localparam int DEPTH = `PROC_QUEUE_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  mem_req_t             entries [DEPTH];
  logic     [PTR_W-1:0] head;
  logic     [PTR_W-1:0] tail;
  logic     [CNT_W-1:0] count;
  logic                 empty;
  logic                 full;
  logic                 do_enq;
  logic                 do_deq;
  logic                 wr_en;
  logic                 rd_en;

  assign empty = (count == '0);
  assign full  = (count == CNT_W'(DEPTH));

  // Empty queue shows the enq side directly
  assign deq_val = empty ? enq_val : 1'b1;
  assign deq_msg = empty ? enq_msg : entries[head];
  assign enq_rdy = !full;

  assign do_enq = enq_val && enq_rdy;
  assign do_deq = deq_val && deq_rdy;

  // A bypassed message is never stored
  assign wr_en = do_enq && !(empty && do_deq);
  assign rd_en = do_deq && !empty;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      entries[tail] <= enq_msg;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (wr_en) begin
        tail <= (tail == PTR_W'(DEPTH - 1)) ? '0 : tail + 1'b1;
      end
      if (rd_en) begin
        head <= (head == PTR_W'(DEPTH - 1)) ? '0 : head + 1'b1;
      end
      count <= count + CNT_W'(wr_en) - CNT_W'(rd_en);
    end
  end

  // A full queue with no dequeue takes nothing in
  a_no_enq_when_full : assert property (
    @(posedge clk) disable iff (!rst_n)
    (full && !do_deq) |=> (full && $stable(head) && $stable(tail))
  ) else $error("request queue accepted an enqueue while full");

endmodule

/* rtl/proc_fetch.sv */
// Instruction fetch
// Holds the pc and issues epoch-tagged requests, with redirect and halt

`timescale 1ns/1ps

`include "proc_cfg.svh"

module proc_fetch
  import proc_mem_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,

  // Request stream towards the queue
  output mem_req_t req_msg,
  output logic     req_val,
  input  logic     req_rdy,

  // Branch redirect from execute
  input  logic     redir_val,
  input  addr_t    redir_pc,

  // Execute state
  input  mem_tag_t epoch,
  input  logic     halted
);

  addr_t pc;
  logic  active;
  logic  fire;

  // No request in a redirect cycle since the pc is about to be replaced
  assign req_val = active && !halted && !redir_val;

  assign req_msg.tag  = epoch;
  assign req_msg.addr = pc;

  assign fire = req_val && req_rdy;

  // Active goes high on the first edge out of reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      active <= 1'b0;
    end else begin
      active <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= `PROC_RESET_VECTOR;
    end else if (redir_val) begin
      pc <= redir_pc;
    end else if (fire) begin
      pc <= pc + 32'd4;
    end
  end

  // Once execute halts, the pc stays where fetch stopped
  a_quiet_after_halt : assert property (
    @(posedge clk) disable iff (!rst_n)
    halted |=> (halted && $stable(pc))
  ) else $error("fetch pc moved after halt");

endmodule

/* rtl/proc_mem_pkg.sv */
// Memory message types
// Address and data words plus the tagged request and response messages

package proc_mem_pkg;

  // Byte address and data word
  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;

  // Opaque tag that carries the fetch epoch
  typedef logic mem_tag_t;

  // Instruction fetch request of 33 bits
  typedef struct packed {
    mem_tag_t tag;
    addr_t    addr;
  } mem_req_t;

  // Instruction fetch response of 33 bits
  typedef struct packed {
    mem_tag_t tag;
    word_t    data;
  } mem_resp_t;

endpackage

/* rtl/proc_isa_pkg.sv */
// Instruction set types
// Opcode encodings, register index, immediate and instruction layout

package proc_isa_pkg;

  // Opcodes
  // Any code not listed executes as a no-op
  typedef enum logic [3:0] {
    OP_NOP  = 4'd0,
    OP_ADD  = 4'd1,
    OP_SUB  = 4'd2,
    OP_AND  = 4'd3,
    OP_ADDI = 4'd4,
    OP_BNE  = 4'd5,
    OP_OUT  = 4'd6,
    OP_HALT = 4'd7
  } opcode_t;

  // Register index into the eight-entry file
  typedef logic [2:0] reg_idx_t;

  // Signed immediate that branches scale by 4
  typedef logic signed [15:0] imm_t;

  // ----------------------------------------------------------------------
  // Instruction word with the most significant field first
  // ----------------------------------------------------------------------
  //
  //  31   28 27 25 24 22 21 19 18 16 15             0
  // | opcode |  rd |  rs |  rt | --- |      imm      |
  //
  typedef struct packed {
    opcode_t    opcode;
    reg_idx_t   rd;
    reg_idx_t   rs;
    reg_idx_t   rt;
    logic [2:0] unused;
    imm_t       imm;
  } inst_t;

endpackage

/* rtl/proc_cfg.svh */
// Processor core configuration
// Reset vector, fetch queue depth and register file size

`ifndef PROC_CFG_SVH
`define PROC_CFG_SVH

// ----------------------------------------------------------------------
// Fetch
// ----------------------------------------------------------------------

// Address of the first instruction after reset
`define PROC_RESET_VECTOR 32'h0000_1000

// Entries in the instruction request bypass queue
`define PROC_QUEUE_DEPTH 2

// ----------------------------------------------------------------------
// Execute
// ----------------------------------------------------------------------

// Register file entries
// Register 0 always reads as zero
`define PROC_NUM_REGS 8

`endif
